/* mm_pkg.sv */
// shared widths and vector types for the matrix accelerator
// reduced axi channel structs, result matrix type
// register offsets and dma state encoding
`default_nettype none

package mm_pkg;

    // fixed 4x4 job geometry
    localparam int MAT_N  = 4;
    localparam int WORD_W = 32;
    localparam int LINE_W = MAT_N * WORD_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [31:0]       addr_t;
    // column 0 in the upper lane
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [1:0]        line_idx_t;
    // 0 selects matrix a, 1 selects matrix b
    typedef logic              axi_id_t;
    typedef logic [3:0]        beat_cnt_t;

    // len field, 16 beats
    localparam beat_cnt_t BURST_LEN = 4'd15;

    // row-major, mat[row][col]
    typedef word_t [MAT_N-1:0][MAT_N-1:0] mat_t;

    typedef struct packed {
        logic      valid;
        axi_id_t   id;
        addr_t     addr;
        beat_cnt_t len;
    } axi_ar_t;

    typedef struct packed {
        logic    valid;
        axi_id_t id;
        word_t   data;
        logic    last;
    } axi_r_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        beat_cnt_t len;
    } axi_aw_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // host register map
    typedef logic [3:0] reg_addr_t;
    localparam reg_addr_t REG_A_ADDR = 4'h0;
    localparam reg_addr_t REG_B_ADDR = 4'h4;
    localparam reg_addr_t REG_C_ADDR = 4'h8;
    localparam reg_addr_t REG_CTRL   = 4'hC;

    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        RUN_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_t;

endpackage

`default_nettype wire

/* mm_cfg_regs.sv */
// host register block
// matrix base addresses, start pulse, busy/done status and readback
`timescale 1ns/1ps
`default_nettype none

module mm_cfg_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     reg_wr_i,
    input  wire mm_pkg::reg_addr_t  reg_addr_i,
    input  wire mm_pkg::word_t      reg_wdata_i,
    input  wire                     job_done_i,
    output mm_pkg::word_t           reg_rdata_o,
    output mm_pkg::addr_t           mat_a_addr_o,
    output mm_pkg::addr_t           mat_b_addr_o,
    output mm_pkg::addr_t           mat_c_addr_o,
    output logic                    start_o
);

    logic busy_q;
    logic done_q;
    logic ctrl_wr;
    logic start_req;

    assign ctrl_wr = reg_wr_i && (reg_addr_i == mm_pkg::REG_CTRL);
    // start only accepted when idle
    assign start_req = ctrl_wr && reg_wdata_i[0] && !busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            start_o      <= 1'b0;
            mat_a_addr_o <= '0;
            mat_b_addr_o <= '0;
            mat_c_addr_o <= '0;
        end else begin
            // one-cycle pulse after the write edge
            start_o <= start_req;
            if (start_req) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (job_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            // addresses frozen while a job runs
            if (reg_wr_i && !busy_q) begin
                case (reg_addr_i)
                    mm_pkg::REG_A_ADDR: mat_a_addr_o <= reg_wdata_i;
                    mm_pkg::REG_B_ADDR: mat_b_addr_o <= reg_wdata_i;
                    mm_pkg::REG_C_ADDR: mat_c_addr_o <= reg_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // registered readback, one cycle after the address
    always_ff @(posedge clk) begin
        case (reg_addr_i)
            mm_pkg::REG_A_ADDR: reg_rdata_o <= mat_a_addr_o;
            mm_pkg::REG_B_ADDR: reg_rdata_o <= mat_b_addr_o;
            mm_pkg::REG_C_ADDR: reg_rdata_o <= mat_c_addr_o;
            mm_pkg::REG_CTRL:   reg_rdata_o <= {30'd0, done_q, busy_q};
            default:            reg_rdata_o <= '0;
        endcase
    end

    // job completion only arrives while a job runs
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        job_done_i |-> busy_q && !start_o);

endmodule

`default_nettype wire

/* dma_engine.sv */
// dma job controller
// a/b read bursts, beat packing into buffer lines
// multiply start and result write-back burst
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start_i,
    input  wire mm_pkg::addr_t      mat_a_addr_i,
    input  wire mm_pkg::addr_t      mat_b_addr_i,
    input  wire mm_pkg::addr_t      mat_c_addr_i,
    // read side
    output mm_pkg::axi_ar_t         ar_o,
    input  wire                     ar_ready_i,
    input  wire mm_pkg::axi_r_t     r_i,
    output logic                    r_ready_o,
    // write side
    output mm_pkg::axi_aw_t         aw_o,
    input  wire                     aw_ready_i,
    output mm_pkg::axi_w_t          w_o,
    input  wire                     w_ready_i,
    input  wire mm_pkg::axi_b_t     b_i,
    output logic                    b_ready_o,
    // buffer write port, shared by both buffers
    output logic                    buf_a_we_o,
    output logic                    buf_b_we_o,
    output mm_pkg::line_idx_t       buf_waddr_o,
    output mm_pkg::line_t           buf_wdata_o,
    // multiply engine
    output logic                    mm_start_o,
    input  wire                     mm_done_i,
    input  wire mm_pkg::mat_t       mat_c_i,
    output logic                    job_done_o
);

    mm_pkg::dma_state_t state_q;
    mm_pkg::dma_state_t state_d;

    // position of the next beat within its line
    logic [1:0]        word_cnt_q;
    // line count over a then b, msb tells which matrix
    logic [2:0]        line_cnt_q;
    mm_pkg::line_t     line_q;
    mm_pkg::beat_cnt_t w_beat_q;

    logic r_fire;
    logic w_fire;
    logic line_full;
    logic load_done;

    assign r_fire    = r_i.valid && r_ready_o;
    assign w_fire    = w_o.valid && w_ready_i;
    assign line_full = r_fire && (word_cnt_q == 2'd3);
    // eighth line is b line 3, a beats always come first
    assign load_done = buf_b_we_o && (buf_waddr_o == 2'd3);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mm_pkg::IDLE:    if (start_i) state_d = mm_pkg::ADDR_A;
            mm_pkg::ADDR_A:  if (ar_ready_i) state_d = mm_pkg::ADDR_B;
            mm_pkg::ADDR_B:  if (ar_ready_i) state_d = mm_pkg::LOAD;
            mm_pkg::LOAD:    if (load_done) state_d = mm_pkg::RUN_MM;
            mm_pkg::RUN_MM:  if (mm_done_i) state_d = mm_pkg::ADDR_C;
            mm_pkg::ADDR_C:  if (aw_ready_i) state_d = mm_pkg::WRITE_C;
            mm_pkg::WRITE_C: begin
                if (w_fire && (w_beat_q == mm_pkg::BURST_LEN)) begin
                    state_d = mm_pkg::WAIT_B;
                end
            end
            mm_pkg::WAIT_B:  if (b_i.valid) state_d = mm_pkg::IDLE;
            default:         state_d = mm_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= mm_pkg::IDLE;
            word_cnt_q <= 2'd0;
            line_cnt_q <= 3'd0;
            w_beat_q   <= '0;
            buf_a_we_o <= 1'b0;
            buf_b_we_o <= 1'b0;
            mm_start_o <= 1'b0;
        end else begin
            state_q <= state_d;
            // buffer write the cycle after the fourth beat
            buf_a_we_o <= line_full && (r_i.id == 1'b0);
            buf_b_we_o <= line_full && (r_i.id == 1'b1);
            // single pulse on entry to RUN_MM
            mm_start_o <= (state_q == mm_pkg::LOAD) && load_done;
            // counters wrap back to 0 at the end of each load
            if (r_fire) begin
                word_cnt_q <= word_cnt_q + 2'd1;
            end
            if (line_full) begin
                line_cnt_q <= line_cnt_q + 3'd1;
            end
            if (state_q == mm_pkg::ADDR_C) begin
                w_beat_q <= '0;
            end else if (w_fire) begin
                w_beat_q <= w_beat_q + 4'd1;
            end
        end
    end

    // line assembly, first word ends up in the upper lane
    always_ff @(posedge clk) begin
        if (r_fire) begin
            line_q <= {line_q[mm_pkg::LINE_W-mm_pkg::WORD_W-1:0], r_i.data};
        end
        if (line_full) begin
            buf_waddr_o <= line_cnt_q[1:0];
        end
    end

    assign buf_wdata_o = line_q;

    // address channels held by state until handshake
    always_comb begin
        ar_o.valid = (state_q == mm_pkg::ADDR_A) || (state_q == mm_pkg::ADDR_B);
        ar_o.id    = (state_q == mm_pkg::ADDR_B);
        ar_o.addr  = (state_q == mm_pkg::ADDR_B) ? mat_b_addr_i : mat_a_addr_i;
        ar_o.len   = mm_pkg::BURST_LEN;
        aw_o.valid = (state_q == mm_pkg::ADDR_C);
        aw_o.addr  = mat_c_addr_i;
        aw_o.len   = mm_pkg::BURST_LEN;
        // result streamed row-major
        w_o.valid  = (state_q == mm_pkg::WRITE_C);
        w_o.data   = mat_c_i[w_beat_q[3:2]][w_beat_q[1:0]];
        w_o.last   = (w_beat_q == mm_pkg::BURST_LEN);
    end

    // a beats may return while b request is still pending
    assign r_ready_o  = (state_q == mm_pkg::ADDR_B) || (state_q == mm_pkg::LOAD);
    assign b_ready_o  = (state_q == mm_pkg::WAIT_B);
    assign job_done_o = b_ready_o && b_i.valid;

    // pending read request keeps valid and payload
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_o.valid && !ar_ready_i |=> ar_o.valid && $stable(ar_o.addr) && $stable(ar_o.id));

    // result payload held while the memory stalls the beat
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_o.valid && !w_ready_i |=> w_o.valid && $stable(w_o.data) && $stable(w_o.last));

    // memory returns a beats before b beats and marks beat 16 as last
    a_r_order: assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> (r_i.id == line_cnt_q[2])
                   && (r_i.last == ((word_cnt_q == 2'd3) && (line_cnt_q[1:0] == 2'd3))));

endmodule

`default_nettype wire

/* line_buffer.sv */
// four-line matrix buffer
// one write port, registered read port
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  wire                     clk,
    input  wire                     we_i,
    input  wire mm_pkg::line_idx_t  waddr_i,
    input  wire mm_pkg::line_t      wdata_i,
    input  wire mm_pkg::line_idx_t  raddr_i,
    output mm_pkg::line_t           rdata_o
);

    // one line per matrix row
    mm_pkg::line_t mem_q [mm_pkg::MAT_N];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data valid one cycle after raddr
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

`default_nettype wire

/* mm_engine.sv */
// 4x4 multiply engine
// steps rows of a against lines of b, four multipliers per step
// holds the result matrix until the next start
`timescale 1ns/1ps
`default_nettype none

module mm_engine (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start_i,
    output mm_pkg::line_idx_t       buf_raddr_o,
    input  wire mm_pkg::line_t      buf_a_rdata_i,
    input  wire mm_pkg::line_t      buf_b_rdata_i,
    output logic                    done_o,
    output mm_pkg::mat_t            mat_c_o
);

    // column 0 sits in the upper lane
    function automatic mm_pkg::word_t lane(input mm_pkg::line_t line, input logic [1:0] col);
        lane = line[mm_pkg::LINE_W - 1 - col * mm_pkg::WORD_W -: mm_pkg::WORD_W];
    endfunction

    logic              running_q;
    logic              s1_valid_q;
    // step = {i, k}
    mm_pkg::beat_cnt_t step_q;
    mm_pkg::beat_cnt_t s1_step_q;
    logic [1:0]        s1_i;
    logic [1:0]        s1_k;
    // row i of a for the current pass, row i+1 prefetched
    mm_pkg::line_t     a_row_q;
    mm_pkg::line_t     a_nxt_q;
    mm_pkg::word_t     a_word;
    mm_pkg::mat_t      acc_q;

    // both buffers share the index, line k
    assign buf_raddr_o = step_q[1:0];
    assign s1_i        = s1_step_q[3:2];
    assign s1_k        = s1_step_q[1:0];
    // very first step uses a line 0 straight from the buffer
    assign a_word = ((s1_i == 2'd0) && (s1_k == 2'd0)) ? lane(buf_a_rdata_i, 2'd0)
                                                      : lane(a_row_q, s1_k);
    assign mat_c_o = acc_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q  <= 1'b0;
            s1_valid_q <= 1'b0;
            step_q     <= '0;
            done_o     <= 1'b0;
        end else begin
            s1_valid_q <= running_q;
            // after the add of step 15
            done_o <= s1_valid_q && (s1_step_q == 4'd15);
            if (start_i) begin
                running_q <= 1'b1;
                step_q    <= '0;
            end else if (running_q) begin
                step_q <= step_q + 4'd1;
                if (step_q == 4'd15) begin
                    running_q <= 1'b0;
                end
            end
        end
    end

    // accumulate stage, one cycle behind the read
    always_ff @(posedge clk) begin
        s1_step_q <= step_q;
        if (start_i) begin
            acc_q <= '0;
        end else if (s1_valid_q) begin
            // c[i][j] += a[i][k] * b[k][j], low 32 bits
            for (int j = 0; j < mm_pkg::MAT_N; j++) begin
                acc_q[s1_i][j] <= acc_q[s1_i][j] + a_word * lane(buf_b_rdata_i, 2'(j));
            end
        end
        if (s1_valid_q) begin
            if (s1_step_q == 4'd0) begin
                a_row_q <= buf_a_rdata_i;
            end
            // line i+1 of a passes by during pass i
            if (s1_k == s1_i + 2'd1) begin
                a_nxt_q <= buf_a_rdata_i;
            end
            if (s1_k == 2'd3) begin
                a_row_q <= (s1_i == 2'd2) ? buf_a_rdata_i : a_nxt_q;
            end
        end
    end

    // one job at a time, dma waits for done
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> !running_q && !s1_valid_q);

endmodule

`default_nettype wire

/* mm_accel_top.sv */
// accelerator top level
// registers, dma engine, a/b line buffers and multiply engine
`timescale 1ns/1ps
`default_nettype none

module mm_accel_top (
    input  wire                     clk,
    input  wire                     rst_n,
    // host register port
    input  wire                     reg_wr_i,
    input  wire mm_pkg::reg_addr_t  reg_addr_i,
    input  wire mm_pkg::word_t      reg_wdata_i,
    output mm_pkg::word_t           reg_rdata_o,
    // memory bus
    output mm_pkg::axi_ar_t         ar_o,
    input  wire                     ar_ready_i,
    input  wire mm_pkg::axi_r_t     r_i,
    output logic                    r_ready_o,
    output mm_pkg::axi_aw_t         aw_o,
    input  wire                     aw_ready_i,
    output mm_pkg::axi_w_t          w_o,
    input  wire                     w_ready_i,
    input  wire mm_pkg::axi_b_t     b_i,
    output logic                    b_ready_o
);

    mm_pkg::addr_t     mat_a_addr;
    mm_pkg::addr_t     mat_b_addr;
    mm_pkg::addr_t     mat_c_addr;
    logic              start;
    logic              job_done;
    logic              buf_a_we;
    logic              buf_b_we;
    mm_pkg::line_idx_t buf_waddr;
    mm_pkg::line_t     buf_wdata;
    mm_pkg::line_idx_t buf_raddr;
    mm_pkg::line_t     buf_a_rdata;
    mm_pkg::line_t     buf_b_rdata;
    logic              mm_start;
    logic              mm_done;
    mm_pkg::mat_t      mat_c;

    mm_cfg_regs regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr_i     (reg_wr_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .job_done_i   (job_done),
        .reg_rdata_o  (reg_rdata_o),
        .mat_a_addr_o (mat_a_addr),
        .mat_b_addr_o (mat_b_addr),
        .mat_c_addr_o (mat_c_addr),
        .start_o      (start)
    );

    dma_engine dma_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .ar_o         (ar_o),
        .ar_ready_i   (ar_ready_i),
        .r_i          (r_i),
        .r_ready_o    (r_ready_o),
        .aw_o         (aw_o),
        .aw_ready_i   (aw_ready_i),
        .w_o          (w_o),
        .w_ready_i    (w_ready_i),
        .b_i          (b_i),
        .b_ready_o    (b_ready_o),
        .buf_a_we_o   (buf_a_we),
        .buf_b_we_o   (buf_b_we),
        .buf_waddr_o  (buf_waddr),
        .buf_wdata_o  (buf_wdata),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .mat_c_i      (mat_c),
        .job_done_o   (job_done)
    );

    // matrix a lines
    line_buffer buf_a_i (
        .clk     (clk),
        .we_i    (buf_a_we),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (buf_a_rdata)
    );

    // matrix b lines
    line_buffer buf_b_i (
        .clk     (clk),
        .we_i    (buf_b_we),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (buf_raddr),
        .rdata_o (buf_b_rdata)
    );

    mm_engine mm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (mm_start),
        .buf_raddr_o   (buf_raddr),
        .buf_a_rdata_i (buf_a_rdata),
        .buf_b_rdata_i (buf_b_rdata),
        .done_o        (mm_done),
        .mat_c_o       (mat_c)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
// testbench memory model for the reduced axi bus
// serves read and write bursts with random ready and valid gaps
// preload port and write beat count
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire mm_pkg::axi_ar_t    ar_i,
    output logic                    ar_ready_o,
    output mm_pkg::axi_r_t          r_o,
    input  wire                     r_ready_i,
    input  wire mm_pkg::axi_aw_t    aw_i,
    output logic                    aw_ready_o,
    input  wire mm_pkg::axi_w_t     w_i,
    output logic                    w_ready_o,
    output mm_pkg::axi_b_t          b_o,
    input  wire                     b_ready_i,
    // preload from the testbench top
    input  wire                     load_en_i,
    input  wire [9:0]               load_idx_i,
    input  wire mm_pkg::word_t      load_data_i,
    output int                      wr_count_o
);

    function automatic mm_pkg::word_t lcg_step(input mm_pkg::word_t s);
        lcg_step = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 1024 words, 4 KB of byte address space
    mm_pkg::word_t mem_q [1024];
    // pending read bursts, word index and id
    logic [9:0]    rq_base [$];
    logic          rq_id [$];
    logic [9:0]    r_beat;
    logic [9:0]    w_idx;
    logic          b_pend;
    mm_pkg::word_t rnd_q;

    // idle bus until the first reset edge
    initial begin
        ar_ready_o = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        r_o        = '0;
        b_o        = '0;
        wr_count_o = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            // fill pattern depends on every address bit
            for (int i = 0; i < 1024; i++) begin
                mem_q[i] <= 32'h5a5a0000 ^ (mm_pkg::word_t'(i) * 32'h9e3779b1);
            end
            rq_base.delete();
            rq_id.delete();
            r_beat = '0;
            w_idx = '0;
            b_pend = 1'b0;
            rnd_q <= 32'he688f20b;
            ar_ready_o <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o <= 1'b0;
            r_o <= '0;
            b_o <= '0;
            wr_count_o <= 0;
        end else begin
            rnd_q <= lcg_step(rnd_q);
            if (load_en_i) begin
                mem_q[load_idx_i] <= load_data_i;
            end
            // read address channel
            if (ar_i.valid && ar_ready_o) begin
                rq_base.push_back(ar_i.addr[11:2]);
                rq_id.push_back(ar_i.id);
            end
            ar_ready_o <= (rnd_q[31:30] != 2'd0);
            // read data, in request order
            if (r_o.valid && r_ready_i) begin
                if (r_o.last) begin
                    rq_base.delete(0);
                    rq_id.delete(0);
                    r_beat = '0;
                end else begin
                    r_beat = r_beat + 10'd1;
                end
            end
            if (!r_o.valid || r_ready_i) begin
                if ((rq_base.size() > 0) && (rnd_q[29:28] != 2'd0)) begin
                    r_o.valid <= 1'b1;
                    r_o.id    <= rq_id[0];
                    r_o.data  <= mem_q[rq_base[0] + r_beat];
                    r_o.last  <= (r_beat == 10'd15);
                end else begin
                    r_o.valid <= 1'b0;
                end
            end
            // write address and data
            if (aw_i.valid && aw_ready_o) begin
                w_idx = aw_i.addr[11:2];
            end
            aw_ready_o <= (rnd_q[27:26] != 2'd0);
            if (w_i.valid && w_ready_o) begin
                mem_q[w_idx] <= w_i.data;
                w_idx = w_idx + 10'd1;
                wr_count_o <= wr_count_o + 1;
                if (w_i.last) begin
                    b_pend = 1'b1;
                end
            end
            w_ready_o <= (rnd_q[25:24] != 2'd0);
            // write response after the last beat
            if (b_o.valid && b_ready_i) begin
                b_o.valid <= 1'b0;
            end else if (!b_o.valid && b_pend && (rnd_q[23:22] != 2'd0)) begin
                b_o.valid <= 1'b1;
                b_o.resp  <= 2'd0;
                b_pend = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_mm_accel.sv */
// testbench top for the matrix accelerator
// clock, reset, lcg, job stimulus, reference model, bus monitor, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_mm_accel;

    localparam int NUM_JOBS    = 6;
    localparam int CYCLE_LIMIT = 2000;

    logic clk = 1'b0;
    logic rst_n;
    logic reg_wr;
    mm_pkg::reg_addr_t reg_addr;
    mm_pkg::word_t reg_wdata;
    mm_pkg::word_t reg_rdata;
    mm_pkg::axi_ar_t ar;
    mm_pkg::axi_r_t r;
    mm_pkg::axi_aw_t aw;
    mm_pkg::axi_w_t w;
    mm_pkg::axi_b_t b;
    logic ar_ready, r_ready, aw_ready, w_ready, b_ready;
    logic load_en;
    logic [9:0] load_idx;
    mm_pkg::word_t load_data;
    int wr_count;

    // job data, written by the stimulus, read by the monitor
    mm_pkg::addr_t a_addr, b_addr, c_addr;
    mm_pkg::word_t mat_a [16];
    mm_pkg::word_t mat_b [16];
    mm_pkg::word_t ref_c [16];
    mm_pkg::word_t seed_q;
    int main_errs;
    int mon_errs;
    int ar_total, aw_total, w_total;
    int cycle_q;

    always #10 clk = ~clk;

    mm_accel_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .reg_wr_i(reg_wr), .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata),
        .reg_rdata_o(reg_rdata),
        .ar_o(ar), .ar_ready_i(ar_ready), .r_i(r), .r_ready_o(r_ready),
        .aw_o(aw), .aw_ready_i(aw_ready), .w_o(w), .w_ready_i(w_ready),
        .b_i(b), .b_ready_o(b_ready)
    );

    tb_axi_mem mem_i (
        .clk(clk), .rst_n(rst_n),
        .ar_i(ar), .ar_ready_o(ar_ready), .r_o(r), .r_ready_i(r_ready),
        .aw_i(aw), .aw_ready_o(aw_ready), .w_i(w), .w_ready_o(w_ready),
        .b_o(b), .b_ready_i(b_ready),
        .load_en_i(load_en), .load_idx_i(load_idx), .load_data_i(load_data),
        .wr_count_o(wr_count)
    );

    function automatic mm_pkg::word_t lcg_step(input mm_pkg::word_t s);
        lcg_step = s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_rand(output mm_pkg::word_t v);
        seed_q = lcg_step(seed_q);
        v = seed_q;
    endtask

    task automatic check_word(input mm_pkg::word_t got, input mm_pkg::word_t exp,
                              input string msg, output bit ok);
        ok = (got === exp);
        if (!ok) $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
    endtask

    task automatic check_addr(input mm_pkg::addr_t got, input mm_pkg::addr_t exp,
                              input string msg, output bit ok);
        ok = (got === exp);
        if (!ok) $display("MISMATCH at %0t: %s address %h expected %h", $time, msg, got, exp);
    endtask

    task automatic check_status(input mm_pkg::word_t got, input mm_pkg::word_t exp,
                                input string msg, output bit ok);
        ok = (got === exp);
        if (!ok) $display("MISMATCH at %0t: %s status %h expected %h", $time, msg, got, exp);
    endtask

    task automatic write_reg(input mm_pkg::reg_addr_t a, input mm_pkg::word_t d);
        @(posedge clk);
        reg_wr <= 1'b1;
        reg_addr <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // readback is registered, sampled mid-cycle
    task automatic read_reg(input mm_pkg::reg_addr_t a, output mm_pkg::word_t d);
        @(posedge clk);
        reg_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = reg_rdata;
    endtask

    task automatic load_matrix(input mm_pkg::addr_t base, input mm_pkg::word_t m [16]);
        for (int n = 0; n < 16; n++) begin
            @(posedge clk);
            load_en <= 1'b1;
            load_idx <= base[11:2] + 10'(n);
            load_data <= m[n];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // c = a * b with 32-bit wrap
    task automatic compute_reference();
        mm_pkg::word_t acc;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                acc = '0;
                for (int k = 0; k < 4; k++) acc = acc + mat_a[i*4+k] * mat_b[k*4+j];
                ref_c[i*4+j] = acc;
            end
        end
    endtask

    // three distinct 32-word slots, random offset inside each
    task automatic pick_addresses();
        mm_pkg::word_t v;
        logic [4:0] sa, sb, sc;
        next_rand(v);
        sa = v[31:27];
        do begin
            next_rand(v);
            sb = v[31:27];
        end while (sb == sa);
        do begin
            next_rand(v);
            sc = v[31:27];
        end while (sc == sa || sc == sb);
        next_rand(v);
        a_addr = (32'(sa) * 32 + 32'(v[31:28])) * 4;
        b_addr = (32'(sb) * 32 + 32'(v[27:24])) * 4;
        c_addr = (32'(sc) * 32 + 32'(v[23:20])) * 4;
    endtask

    // bus monitor, counts are cumulative over the run
    always @(posedge clk) begin
        bit ok;
        if (rst_n) begin
            if (ar.valid && ar_ready) begin
                check_addr(ar.addr, (ar_total % 2 == 0) ? a_addr : b_addr, "ar", ok);
                if (!ok) mon_errs++;
                check_word(32'(ar.id), 32'(ar_total % 2), "ar id", ok);
                if (!ok) mon_errs++;
                check_word(32'(ar.len), 32'd15, "ar len", ok);
                if (!ok) mon_errs++;
                ar_total++;
            end
            if (aw.valid && aw_ready) begin
                check_addr(aw.addr, c_addr, "aw", ok);
                if (!ok) mon_errs++;
                check_word(32'(aw.len), 32'd15, "aw len", ok);
                if (!ok) mon_errs++;
                aw_total++;
            end
            if (w.valid && w_ready) begin
                check_word(w.data, ref_c[w_total % 16], "w beat", ok);
                if (!ok) mon_errs++;
                check_word(32'(w.last), 32'(w_total % 16 == 15), "w last", ok);
                if (!ok) mon_errs++;
                w_total++;
            end
        end
    end

    // 6 jobs at up to 300 cycles each
    always @(posedge clk) begin
        cycle_q <= cycle_q + 1;
        if (cycle_q == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, dma state %s", cycle_q,
                     dut_i.dma_i.state_q.name());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        mm_pkg::word_t rd;
        bit ok;
        int ar0, aw0, w0, wr0;
        rst_n = 1'b0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        load_en = 1'b0;
        load_idx = '0;
        load_data = '0;
        seed_q = 32'he688f20b;
        main_errs = 0;
        mon_errs = 0;
        ar_total = 0;
        aw_total = 0;
        w_total = 0;
        cycle_q = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word({29'd0, ar.valid, aw.valid, w.valid}, '0, "valids after reset", ok);
        if (!ok) main_errs++;
        read_reg(mm_pkg::REG_CTRL, rd);
        check_status(rd, 32'h0, "after reset", ok);
        if (!ok) main_errs++;
        for (int job = 0; job < NUM_JOBS; job++) begin
            pick_addresses();
            for (int n = 0; n < 16; n++) begin
                next_rand(mat_a[n]);
                next_rand(mat_b[n]);
            end
            compute_reference();
            load_matrix(a_addr, mat_a);
            load_matrix(b_addr, mat_b);
            ar0 = ar_total;
            aw0 = aw_total;
            w0 = w_total;
            wr0 = wr_count;
            write_reg(mm_pkg::REG_A_ADDR, a_addr);
            write_reg(mm_pkg::REG_B_ADDR, b_addr);
            write_reg(mm_pkg::REG_C_ADDR, c_addr);
            read_reg(mm_pkg::REG_C_ADDR, rd);
            check_addr(rd, c_addr, "c register", ok);
            if (!ok) main_errs++;
            write_reg(mm_pkg::REG_CTRL, 32'h1);
            read_reg(mm_pkg::REG_CTRL, rd);
            check_status(rd, 32'h1, "busy after start", ok);
            if (!ok) main_errs++;
            // ignored, job already running
            write_reg(mm_pkg::REG_CTRL, 32'h1);
            do begin
                read_reg(mm_pkg::REG_CTRL, rd);
            end while (rd[1] == 1'b0);
            check_status(rd, 32'h2, "done after job", ok);
            if (!ok) main_errs++;
            check_word(32'(ar_total - ar0), 32'd2, "read bursts per job", ok);
            if (!ok) main_errs++;
            check_word(32'(aw_total - aw0), 32'd1, "write bursts per job", ok);
            if (!ok) main_errs++;
            check_word(32'(w_total - w0), 32'd16, "write beats per job", ok);
            if (!ok) main_errs++;
            check_word(32'(wr_count - wr0), 32'd16, "write log count", ok);
            if (!ok) main_errs++;
        end
        $display("errors: sequence %0d, bus monitor %0d", main_errs, mon_errs);
        if (main_errs == 0 && mon_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
mm_pkg.sv
mm_cfg_regs.sv
dma_engine.sv
line_buffer.sv
mm_engine.sv
mm_accel_top.sv
tb_axi_mem.sv
tb_mm_accel.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mm_accel
FILELIST  ?= sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
